// ==== cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    // Data path and address width
    localparam int xlen = 16;

    // Register file geometry
    localparam int reg_count  = 8;
    localparam int reg_addr_w = 3;

    // Data memory depth in words
    localparam int dmem_words = 64;

    // Five-bit opcode
    typedef logic [4:0] opcode_t;

    // Opcode map
    // Jumps share 001xx and conditional branches share 011xx
    localparam opcode_t op_halt = 5'b00000;
    localparam opcode_t op_nop  = 5'b00001;
    localparam opcode_t op_j    = 5'b00100;
    localparam opcode_t op_beqz = 5'b01100;
    localparam opcode_t op_bnez = 5'b01101;
    localparam opcode_t op_addi = 5'b01000;
    localparam opcode_t op_st   = 5'b10000;
    localparam opcode_t op_ld   = 5'b10001;
    localparam opcode_t op_lbi  = 5'b11000;
    localparam opcode_t op_alu  = 5'b11011;

    // ALU function field of the R format
    localparam logic [1:0] fn_add = 2'b00;
    localparam logic [1:0] fn_sub = 2'b01;
    localparam logic [1:0] fn_and = 2'b10;
    localparam logic [1:0] fn_xor = 2'b11;

    // One instruction word seen through its three formats
    // i_fmt rd sits on the same bits as r_fmt rt
    typedef union packed {
        struct packed {
            opcode_t   opcode;
            logic [2:0] rs;
            logic [2:0] rt;
            logic [2:0] rd;
            logic [1:0] func;
        } r_fmt;
        struct packed {
            opcode_t   opcode;
            logic [2:0] rs;
            logic [2:0] rd;
            logic [4:0] imm;
        } i_fmt;
        struct packed {
            opcode_t   opcode;
            logic [2:0] rs;
            logic [7:0] imm;
        } b_fmt;
    } instr_u;

endpackage

`default_nettype wire

// ==== fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import cpu_pkg::*; (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic            pc_hold,
    input  wire logic            id_hold,
    input  wire logic            flush_front,
    input  wire logic            redirect,
    input  wire logic [xlen-1:0] redirect_pc,
    input  wire logic [xlen-1:0] imem_data,
    output logic      [xlen-1:0] imem_addr,
    output opcode_t              if_opcode,
    output logic      [xlen-1:0] ifid_instr,
    output logic      [xlen-1:0] ifid_pc,
    output logic                 ifid_valid
);

    logic [xlen-1:0] pc;
    // Word now in IF was already passed into IF/ID while the PC sat still
    logic            held;
    logic            take_word;

    assign imem_addr = pc;
    assign if_opcode = opcode_t'(imem_data[15:11]);

    // A fresh word moves into IF/ID
    assign take_word = !flush_front && !id_hold && !held;

    // Program counter, redirect beats any hold
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc   <= '0;
            held <= 1'b0;
        end else if (redirect) begin
            pc   <= redirect_pc;
            held <= 1'b0;
        end else if (!pc_hold) begin
            pc   <= pc + xlen'(2);
            held <= 1'b0;
        end else if (take_word) begin
            held <= 1'b1;
        end
    end

    // IF/ID valid bit
    // Repeated word under a hold becomes a bubble
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ifid_valid <= 1'b0;
        end else if (!id_hold || flush_front) begin
            ifid_valid <= take_word;
        end
    end

    // IF/ID payload
    always_ff @(posedge clk) begin
        if (take_word) begin
            ifid_instr <= imem_data;
            ifid_pc    <= pc;
        end
    end

    // Jump and branch targets stay on word boundaries
    a_redirect_even: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |-> !redirect_pc[0]);

endmodule

`default_nettype wire

// ==== decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage import cpu_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic [xlen-1:0]       ifid_instr,
    input  wire logic [xlen-1:0]       ifid_pc,
    input  wire logic                  ifid_valid,
    input  wire logic                  ex_bubble,
    input  wire logic                  flush_front,
    input  wire logic                  wb_en,
    input  wire logic [reg_addr_w-1:0] wb_reg,
    input  wire logic [xlen-1:0]       wb_data,
    output opcode_t                    id_opcode,
    output logic      [reg_addr_w-1:0] id_rs,
    output logic      [reg_addr_w-1:0] id_rt,
    output logic                       id_uses_rs,
    output logic                       id_uses_rt,
    output logic                       idex_valid,
    output opcode_t                    idex_opcode,
    output logic      [1:0]            idex_func,
    output logic      [xlen-1:0]       idex_a,
    output logic      [xlen-1:0]       idex_b,
    output logic      [xlen-1:0]       idex_imm,
    output logic      [xlen-1:0]       idex_pc,
    output logic                       idex_wr_en,
    output logic      [reg_addr_w-1:0] idex_wr_reg
);

    instr_u                  ins;
    logic [xlen-1:0]         regs [reg_count];
    logic [xlen-1:0]         rd_a;
    logic [xlen-1:0]         rd_b;
    logic [xlen-1:0]         imm;
    logic                    writes;
    logic [reg_addr_w-1:0]   dest;
    logic                    load_bubble;

    assign ins       = instr_u'(ifid_instr);
    assign id_opcode = ins.r_fmt.opcode;
    assign id_rs     = ins.r_fmt.rs;
    // Second read port, also the ST data register
    assign id_rt     = ins.r_fmt.rt;

    // J, LBI, NOP and HALT leave rs alone
    assign id_uses_rs = !(id_opcode inside {op_j, op_lbi, op_nop, op_halt});
    // Only ALU ops and ST read the second field
    assign id_uses_rt = (id_opcode == op_alu) || (id_opcode == op_st);

    // Register file, written from writeback
    always_ff @(posedge clk) begin
        if (wb_en) begin
            regs[wb_reg] <= wb_data;
        end
    end

    // Write-through so a same-cycle write is seen
    assign rd_a = (wb_en && wb_reg == id_rs) ? wb_data : regs[id_rs];
    assign rd_b = (wb_en && wb_reg == id_rt) ? wb_data : regs[id_rt];

    // Immediate sign extension per format
    always_comb begin
        case (id_opcode)
            op_addi, op_ld, op_st: imm = xlen'(signed'(ins.i_fmt.imm));
            op_beqz, op_bnez, op_lbi: imm = xlen'(signed'(ins.b_fmt.imm));
            // J reads rs and imm as one 11-bit displacement
            op_j:    imm = xlen'(signed'({ins.b_fmt.rs, ins.b_fmt.imm}));
            default: imm = '0;
        endcase
    end

    // Destination register
    always_comb begin
        writes = 1'b1;
        case (id_opcode)
            op_alu:        dest = ins.r_fmt.rd;
            op_addi, op_ld: dest = ins.i_fmt.rd;
            op_lbi:        dest = ins.b_fmt.rs;
            default: begin
                dest   = '0;
                writes = 1'b0;
            end
        endcase
    end

    assign load_bubble = ex_bubble || flush_front || !ifid_valid;

    // ID/EX control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idex_valid  <= 1'b0;
            idex_wr_en  <= 1'b0;
            idex_opcode <= op_nop;
        end else begin
            idex_valid  <= !load_bubble;
            idex_wr_en  <= !load_bubble && writes;
            idex_opcode <= load_bubble ? op_nop : id_opcode;
        end
    end

    // ID/EX payload
    always_ff @(posedge clk) begin
        idex_func   <= ins.r_fmt.func;
        idex_a      <= rd_a;
        idex_b      <= rd_b;
        idex_imm    <= imm;
        idex_pc     <= ifid_pc;
        idex_wr_reg <= dest;
    end

    // Register file never takes an unknown value
    a_wb_known: assert property (@(posedge clk) disable iff (!rst_n)
        wb_en |-> !$isunknown(wb_reg) && !$isunknown(wb_data));

endmodule

`default_nettype wire

// ==== hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit import cpu_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire opcode_t               if_opcode,
    input  wire opcode_t               id_opcode,
    input  wire logic [reg_addr_w-1:0] id_rs,
    input  wire logic [reg_addr_w-1:0] id_rt,
    input  wire logic                  id_uses_rs,
    input  wire logic                  id_uses_rt,
    input  wire logic                  ifid_valid,
    input  wire opcode_t               idex_opcode,
    input  wire logic                  idex_valid,
    input  wire logic                  ex_wr_en,
    input  wire logic [reg_addr_w-1:0] ex_wr_reg,
    input  wire logic                  mem_wr_en,
    input  wire logic [reg_addr_w-1:0] mem_wr_reg,
    input  wire logic                  br_resolve,
    input  wire logic                  br_taken,
    input  wire logic                  redirect,
    output logic                       pc_hold,
    output logic                       id_hold,
    output logic                       ex_bubble,
    output logic                       flush_front,
    output logic                       predict_taken
);

    logic [1:0] state;
    logic [1:0] nxt_state;
    logic       raw_ex;
    logic       raw_mem;
    logic       data_hazard;
    logic       ctrl_if;
    logic       ctrl_id;
    logic       ctrl_ex;
    logic       halt_if;

    // Read-after-write against the writer in EX
    assign raw_ex = ex_wr_en &&
        ((id_uses_rs && ex_wr_reg == id_rs) || (id_uses_rt && ex_wr_reg == id_rt));

    // Same check against MEM, writeback is covered by write-through
    assign raw_mem = mem_wr_en &&
        ((id_uses_rs && mem_wr_reg == id_rs) || (id_uses_rt && mem_wr_reg == id_rt));

    assign data_hazard = ifid_valid && (raw_ex || raw_mem);

    // Jump, or branch expected taken, somewhere in the front end
    assign ctrl_if = (if_opcode == op_j) ||
        ((if_opcode inside {op_beqz, op_bnez}) && predict_taken);
    assign ctrl_id = ifid_valid && ((id_opcode == op_j) ||
        ((id_opcode inside {op_beqz, op_bnez}) && predict_taken));
    assign ctrl_ex = idex_valid && ((idex_opcode == op_j) ||
        ((idex_opcode inside {op_beqz, op_bnez}) && predict_taken));

    // HALT parks fetch for good
    assign halt_if = (if_opcode == op_halt);

    // Redirect wins over every hold
    assign pc_hold     = !redirect && (data_hazard || ctrl_if || ctrl_id || ctrl_ex || halt_if);
    assign id_hold     = !redirect && data_hazard;
    assign ex_bubble   = !redirect && data_hazard;
    assign flush_front = redirect;

    // 00 and 01 predict not taken, 10 and 11 predict taken
    assign predict_taken = state[1];

    // Saturating step toward the resolved outcome
    always_comb begin
        nxt_state = state;
        if (br_resolve) begin
            case (state)
                2'b00: nxt_state = br_taken ? 2'b01 : 2'b00;
                2'b01: nxt_state = br_taken ? 2'b10 : 2'b00;
                2'b10: nxt_state = br_taken ? 2'b11 : 2'b01;
                default: nxt_state = br_taken ? 2'b11 : 2'b10;
            endcase
        end
    end

    // Starts weak not taken
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= 2'b01;
        end else begin
            state <= nxt_state;
        end
    end

    // A stalled instruction stays parked in IF/ID
    a_stall_keeps_id: assert property (@(posedge clk) disable iff (!rst_n)
        id_hold |=> ifid_valid && $stable(id_opcode) && $stable(id_rs) && $stable(id_rt));

endmodule

`default_nettype wire

// ==== execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage import cpu_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  idex_valid,
    input  wire opcode_t               idex_opcode,
    input  wire logic [1:0]            idex_func,
    input  wire logic [xlen-1:0]       idex_a,
    input  wire logic [xlen-1:0]       idex_b,
    input  wire logic [xlen-1:0]       idex_imm,
    input  wire logic [xlen-1:0]       idex_pc,
    input  wire logic                  idex_wr_en,
    input  wire logic [reg_addr_w-1:0] idex_wr_reg,
    input  wire logic                  predict_taken,
    output logic                       ex_wr_en,
    output logic      [reg_addr_w-1:0] ex_wr_reg,
    output logic                       br_resolve,
    output logic                       br_taken,
    output logic                       redirect,
    output logic      [xlen-1:0]       redirect_pc,
    output logic                       exmem_valid,
    output opcode_t                    exmem_opcode,
    output logic      [xlen-1:0]       exmem_result,
    output logic      [xlen-1:0]       exmem_store_data,
    output logic                       exmem_wr_en,
    output logic      [reg_addr_w-1:0] exmem_wr_reg
);

    logic [xlen-1:0] alu_out;
    logic [xlen-1:0] result;
    logic [xlen-1:0] seq_pc;
    logic [xlen-1:0] target;
    logic            is_jump;
    // Prediction seen while the branch sat in decode
    logic            pred_at_entry;

    assign ex_wr_en  = idex_wr_en;
    assign ex_wr_reg = idex_wr_reg;

    // R-format ALU
    always_comb begin
        case (idex_func)
            fn_add:  alu_out = idex_a + idex_b;
            fn_sub:  alu_out = idex_a - idex_b;
            fn_and:  alu_out = idex_a & idex_b;
            fn_xor:  alu_out = idex_a ^ idex_b;
            default: alu_out = '0;
        endcase
    end

    // ADDI and LD/ST addresses are base plus imm5
    always_comb begin
        case (idex_opcode)
            op_alu:               result = alu_out;
            op_addi, op_ld, op_st: result = idex_a + idex_imm;
            op_lbi:               result = idex_imm;
            default:              result = '0;
        endcase
    end

    // Branch and jump resolution
    assign seq_pc     = idex_pc + xlen'(2);
    assign target     = seq_pc + idex_imm;
    assign is_jump    = idex_valid && (idex_opcode == op_j);
    assign br_resolve = idex_valid && (idex_opcode inside {op_beqz, op_bnez});
    assign br_taken   = br_resolve &&
        ((idex_opcode == op_beqz) == (idex_a == '0));

    // Fall-through was not fetched when taken was predicted
    assign redirect    = is_jump || br_taken || (br_resolve && pred_at_entry);
    assign redirect_pc = (is_jump || br_taken) ? target : seq_pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pred_at_entry <= 1'b0;
        end else begin
            pred_at_entry <= predict_taken;
        end
    end

    // EX/MEM control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exmem_valid  <= 1'b0;
            exmem_wr_en  <= 1'b0;
            exmem_opcode <= op_nop;
        end else begin
            exmem_valid  <= idex_valid;
            exmem_wr_en  <= idex_wr_en;
            exmem_opcode <= idex_opcode;
        end
    end

    // EX/MEM payload
    always_ff @(posedge clk) begin
        exmem_result     <= result;
        exmem_store_data <= idex_b;
        exmem_wr_reg     <= idex_wr_reg;
    end

endmodule

`default_nettype wire

// ==== memory_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module memory_stage import cpu_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  exmem_valid,
    input  wire opcode_t               exmem_opcode,
    input  wire logic [xlen-1:0]       exmem_result,
    input  wire logic [xlen-1:0]       exmem_store_data,
    input  wire logic                  exmem_wr_en,
    input  wire logic [reg_addr_w-1:0] exmem_wr_reg,
    output logic                       mem_wr_en,
    output logic      [reg_addr_w-1:0] mem_wr_reg,
    output logic                       wb_en,
    output logic      [reg_addr_w-1:0] wb_reg,
    output logic      [xlen-1:0]       wb_data,
    output logic                       halted
);

    localparam int aw = $clog2(dmem_words);

    logic [xlen-1:0] dmem [dmem_words];
    logic [aw-1:0]   word_idx;
    logic            is_ld;

    assign mem_wr_en  = exmem_wr_en;
    assign mem_wr_reg = exmem_wr_reg;

    // Byte address to word index, wraps at 64 words
    assign word_idx = exmem_result[aw:1];
    assign is_ld    = exmem_valid && (exmem_opcode == op_ld);

    always_ff @(posedge clk) begin
        if (exmem_valid && exmem_opcode == op_st) begin
            dmem[word_idx] <= exmem_store_data;
        end
    end

    // MEM/WB control, halted is sticky
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_en  <= 1'b0;
            halted <= 1'b0;
        end else begin
            wb_en  <= exmem_wr_en;
            halted <= halted || (exmem_valid && exmem_opcode == op_halt);
        end
    end

    // MEM/WB payload, load data read combinationally
    always_ff @(posedge clk) begin
        wb_reg  <= exmem_wr_reg;
        wb_data <= is_ld ? dmem[word_idx] : exmem_result;
    end

endmodule

`default_nettype wire

// ==== cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_top import cpu_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic [xlen-1:0]       imem_data,
    output logic      [xlen-1:0]       imem_addr,
    output logic                       wb_valid,
    output logic      [reg_addr_w-1:0] wb_reg,
    output logic      [xlen-1:0]       wb_data,
    output logic                       halted
);

    // Hazard controls
    logic pc_hold;
    logic id_hold;
    logic ex_bubble;
    logic flush_front;
    logic predict_taken;

    // IF/ID
    opcode_t         if_opcode;
    logic [xlen-1:0] ifid_instr;
    logic [xlen-1:0] ifid_pc;
    logic            ifid_valid;

    // Decode to hazard unit
    opcode_t               id_opcode;
    logic [reg_addr_w-1:0] id_rs;
    logic [reg_addr_w-1:0] id_rt;
    logic                  id_uses_rs;
    logic                  id_uses_rt;

    // ID/EX
    logic                  idex_valid;
    opcode_t               idex_opcode;
    logic [1:0]            idex_func;
    logic [xlen-1:0]       idex_a;
    logic [xlen-1:0]       idex_b;
    logic [xlen-1:0]       idex_imm;
    logic [xlen-1:0]       idex_pc;
    logic                  idex_wr_en;
    logic [reg_addr_w-1:0] idex_wr_reg;

    // Execute results and redirect
    logic                  ex_wr_en;
    logic [reg_addr_w-1:0] ex_wr_reg;
    logic                  br_resolve;
    logic                  br_taken;
    logic                  redirect;
    logic [xlen-1:0]       redirect_pc;

    // EX/MEM
    logic                  exmem_valid;
    opcode_t               exmem_opcode;
    logic [xlen-1:0]       exmem_result;
    logic [xlen-1:0]       exmem_store_data;
    logic                  exmem_wr_en;
    logic [reg_addr_w-1:0] exmem_wr_reg;

    // Memory stage writer and writeback port
    logic                  mem_wr_en;
    logic [reg_addr_w-1:0] mem_wr_reg;
    logic                  wb_en;

    assign wb_valid = wb_en;

    fetch_stage fetch_stage_i (
        .clk, .rst_n, .pc_hold, .id_hold, .flush_front, .redirect, .redirect_pc,
        .imem_data, .imem_addr, .if_opcode, .ifid_instr, .ifid_pc, .ifid_valid
    );

    decode_stage decode_stage_i (
        .clk, .rst_n, .ifid_instr, .ifid_pc, .ifid_valid, .ex_bubble, .flush_front,
        .wb_en, .wb_reg, .wb_data,
        .id_opcode, .id_rs, .id_rt, .id_uses_rs, .id_uses_rt,
        .idex_valid, .idex_opcode, .idex_func, .idex_a, .idex_b, .idex_imm,
        .idex_pc, .idex_wr_en, .idex_wr_reg
    );

    hazard_unit hazard_unit_i (
        .clk, .rst_n, .if_opcode, .id_opcode, .id_rs, .id_rt, .id_uses_rs,
        .id_uses_rt, .ifid_valid, .idex_opcode, .idex_valid, .ex_wr_en, .ex_wr_reg,
        .mem_wr_en, .mem_wr_reg, .br_resolve, .br_taken, .redirect,
        .pc_hold, .id_hold, .ex_bubble, .flush_front, .predict_taken
    );

    execute_stage execute_stage_i (
        .clk, .rst_n, .idex_valid, .idex_opcode, .idex_func, .idex_a, .idex_b,
        .idex_imm, .idex_pc, .idex_wr_en, .idex_wr_reg, .predict_taken,
        .ex_wr_en, .ex_wr_reg, .br_resolve, .br_taken, .redirect, .redirect_pc,
        .exmem_valid, .exmem_opcode, .exmem_result, .exmem_store_data,
        .exmem_wr_en, .exmem_wr_reg
    );

    memory_stage memory_stage_i (
        .clk, .rst_n, .exmem_valid, .exmem_opcode, .exmem_result, .exmem_store_data,
        .exmem_wr_en, .exmem_wr_reg, .mem_wr_en, .mem_wr_reg,
        .wb_en, .wb_reg, .wb_data, .halted
    );

endmodule

`default_nettype wire

// ==== tb_cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_top import cpu_pkg::*; ();

    localparam int n_progs     = 5;
    localparam int max_words   = 24;
    // Watchdog budget over the whole run
    localparam int cycle_limit = 40 * max_words * n_progs;
    localparam logic [15:0] halt_w = {op_halt, 11'd0};

    logic        clk;
    logic        rst_n;
    logic [15:0] imem_data;
    logic [15:0] imem_addr;
    logic        wb_valid;
    logic [2:0]  wb_reg;
    logic [15:0] wb_data;
    logic        halted;

    // Program table, one row per program
    logic [15:0] prog_tbl [n_progs][max_words];
    int          prog_len [n_progs];
    int          cur_prog;
    int          err_count;
    int          cycle_count;
    logic [31:0] rng;

    // Reference model state and expected writeback stream
    logic [15:0] m_reg [8];
    logic [15:0] m_mem [64];
    logic [2:0]  exp_reg [$];
    logic [15:0] exp_val [$];

    cpu_top cpu_top_i (
        .clk, .rst_n, .imem_data, .imem_addr, .wb_valid, .wb_reg, .wb_data, .halted
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Instruction ROM answers on the falling edge
    always @(negedge clk) begin
        imem_data <= word_at(cur_prog, imem_addr);
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            stop_with_error($sformatf("core did not halt within %0d cycles", cycle_limit));
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Encoders, rd = rs op rt
    function automatic logic [15:0] r_word(input logic [1:0] func, input int rd,
                                           input int rs, input int rt);
        return {op_alu, 3'(rs), 3'(rt), 3'(rd), func};
    endfunction

    // ST puts its data register in the rd slot
    function automatic logic [15:0] i_word(input opcode_t op, input int rd,
                                           input int rs, input int imm);
        return {op, 3'(rs), 3'(rd), 5'(imm)};
    endfunction

    function automatic logic [15:0] b_word(input opcode_t op, input int rs, input int imm);
        return {op, 3'(rs), 8'(imm)};
    endfunction

    function automatic logic [15:0] j_word(input int disp);
        return {op_j, 11'(disp)};
    endfunction

    // Past the end of a program the ROM reads HALT
    function automatic logic [15:0] word_at(input int p, input logic [15:0] addr);
        int idx;
        idx = int'(addr[15:1]);
        if (idx < prog_len[p]) begin
            return prog_tbl[p][idx];
        end
        return halt_w;
    endfunction

    task automatic stop_with_error(input string msg);
        err_count = err_count + 1;
        $display("ERROR at %0t: %s", $time, msg);
        $display("Simulation FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            err_count = err_count + 1;
            $display("[FAIL] time %0t %s got %h expected %h", $time, name, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic add_word(input int p, input logic [15:0] w);
        prog_tbl[p][prog_len[p]] = w;
        prog_len[p] = prog_len[p] + 1;
    endtask

    task automatic build_table();
        int i;
        for (i = 0; i < n_progs; i++) begin
            prog_len[i] = 0;
        end
        // Dependent ALU and ADDI chain, word after HALT must stay dead
        add_word(0, b_word(op_lbi, 1, 5));
        add_word(0, b_word(op_lbi, 2, -3));
        add_word(0, r_word(fn_add, 3, 1, 2));
        add_word(0, i_word(op_addi, 4, 3, 7));
        add_word(0, r_word(fn_sub, 5, 4, 1));
        add_word(0, r_word(fn_xor, 6, 5, 2));
        add_word(0, r_word(fn_and, 7, 6, 4));
        add_word(0, i_word(op_addi, 1, 1, -1));
        add_word(0, r_word(fn_add, 2, 1, 7));
        add_word(0, halt_w);
        add_word(0, b_word(op_lbi, 1, 1));
        // Store and load, same address, aliasing addresses, load-use
        add_word(1, b_word(op_lbi, 1, 8));
        add_word(1, b_word(op_lbi, 2, 85));
        add_word(1, i_word(op_st, 2, 1, 0));
        add_word(1, i_word(op_ld, 3, 1, 0));
        add_word(1, r_word(fn_add, 4, 3, 3));
        add_word(1, b_word(op_lbi, 5, -128));
        add_word(1, i_word(op_st, 5, 1, 2));
        // 0xff8a aliases byte address 10
        add_word(1, b_word(op_lbi, 6, -118));
        add_word(1, i_word(op_ld, 7, 6, 0));
        add_word(1, i_word(op_st, 4, 6, 2));
        add_word(1, i_word(op_ld, 3, 1, 4));
        add_word(1, i_word(op_addi, 3, 3, 1));
        add_word(1, halt_w);
        // Loop of three taken then three not-taken branches
        add_word(2, b_word(op_lbi, 1, 3));
        add_word(2, b_word(op_lbi, 3, 1));
        add_word(2, b_word(op_lbi, 6, 0));
        add_word(2, b_word(op_lbi, 7, 0));
        add_word(2, b_word(op_bnez, 3, 2));
        add_word(2, i_word(op_addi, 7, 7, 1));
        add_word(2, b_word(op_beqz, 6, 2));
        add_word(2, i_word(op_addi, 7, 7, 2));
        add_word(2, b_word(op_bnez, 3, 2));
        add_word(2, i_word(op_addi, 7, 7, 4));
        add_word(2, b_word(op_beqz, 3, 2));
        add_word(2, i_word(op_addi, 7, 7, 1));
        add_word(2, b_word(op_bnez, 6, 2));
        add_word(2, i_word(op_addi, 7, 7, 1));
        add_word(2, b_word(op_beqz, 3, 2));
        add_word(2, i_word(op_addi, 7, 7, 1));
        add_word(2, i_word(op_addi, 1, 1, -1));
        add_word(2, b_word(op_bnez, 1, -28));
        add_word(2, r_word(fn_add, 2, 7, 1));
        add_word(2, halt_w);
        // Forward and backward jumps
        add_word(3, b_word(op_lbi, 1, 1));
        add_word(3, j_word(6));
        add_word(3, b_word(op_lbi, 2, 99));
        add_word(3, i_word(op_addi, 1, 1, 1));
        add_word(3, j_word(6));
        add_word(3, b_word(op_lbi, 3, 7));
        add_word(3, j_word(-8));
        add_word(3, b_word(op_lbi, 4, 55));
        add_word(3, r_word(fn_add, 5, 1, 3));
        add_word(3, halt_w);
        add_word(3, b_word(op_lbi, 6, 1));
        // Random row, every register seeded first
        rng = 32'h9280;
        for (i = 0; i < 8; i++) begin
            rng = xorshift(rng);
            add_word(4, b_word(op_lbi, i, int'(rng[7:0])));
        end
        for (i = 8; i < max_words - 1; i++) begin
            rng = xorshift(rng);
            if (rng[1:0] == 2'd0) begin
                add_word(4, b_word(op_lbi, int'(rng[4:2]), int'(rng[15:8])));
            end else begin
                add_word(4, r_word(rng[3:2], int'(rng[6:4]), int'(rng[9:7]),
                                   int'(rng[12:10])));
            end
        end
        add_word(4, halt_w);
    endtask

    task automatic note_write(input logic [2:0] r, input logic [15:0] v);
        m_reg[r] = v;
        exp_reg.push_back(r);
        exp_val.push_back(v);
    endtask

    // Sequential ISA model, one instruction per step
    task automatic run_model(input int p);
        logic [15:0] w;
        logic [15:0] pc;
        logic [15:0] imm5;
        logic [15:0] imm8;
        logic [15:0] disp;
        logic [15:0] addr;
        logic [15:0] val;
        logic [2:0]  rs;
        logic [2:0]  rt;
        logic        done;
        int          steps;
        exp_reg.delete();
        exp_val.delete();
        pc = '0;
        done = 1'b0;
        steps = 0;
        while (!done) begin
            w = word_at(p, pc);
            rs = w[10:8];
            rt = w[7:5];
            imm5 = {{11{w[4]}}, w[4:0]};
            imm8 = {{8{w[7]}}, w[7:0]};
            disp = {{5{w[10]}}, w[10:0]};
            pc = pc + 16'd2;
            case (opcode_t'(w[15:11]))
                op_halt: done = 1'b1;
                op_j: pc = pc + disp;
                op_beqz: pc = (m_reg[rs] == 16'd0) ? pc + imm8 : pc;
                op_bnez: pc = (m_reg[rs] != 16'd0) ? pc + imm8 : pc;
                op_addi: note_write(rt, m_reg[rs] + imm5);
                op_lbi: note_write(rs, imm8);
                op_ld: begin
                    addr = m_reg[rs] + imm5;
                    note_write(rt, m_mem[addr[6:1]]);
                end
                op_st: begin
                    addr = m_reg[rs] + imm5;
                    m_mem[addr[6:1]] = m_reg[rt];
                end
                op_alu: begin
                    case (w[1:0])
                        fn_add: val = m_reg[rs] + m_reg[rt];
                        fn_sub: val = m_reg[rs] - m_reg[rt];
                        fn_and: val = m_reg[rs] & m_reg[rt];
                        default: val = m_reg[rs] ^ m_reg[rt];
                    endcase
                    note_write(w[4:2], val);
                end
                default: ;
            endcase
            steps = steps + 1;
            if (steps > 4000) begin
                stop_with_error("reference model never reached HALT");
            end
        end
    endtask

    // Reset, then compare writebacks in order until halted
    task automatic run_program(input int p);
        int   n_seen;
        logic finished;
        run_model(p);
        @(negedge clk);
        cur_prog = p;
        rst_n = 1'b0;
        repeat (10) @(negedge clk);
        // Outputs while reset is held
        check_value("imem_addr", imem_addr, 16'h0000);
        check_value("wb_valid", 16'(wb_valid), 16'h0000);
        check_value("halted", 16'(halted), 16'h0000);
        rst_n = 1'b1;
        n_seen = 0;
        finished = 1'b0;
        while (!finished) begin
            @(negedge clk);
            if (wb_valid) begin
                if (n_seen >= exp_reg.size()) begin
                    stop_with_error($sformatf("program %0d wrote back more than expected", p));
                end else begin
                    check_value("wb_reg", 16'(wb_reg), 16'(exp_reg[n_seen]));
                    check_value("wb_data", wb_data, exp_val[n_seen]);
                    n_seen = n_seen + 1;
                end
            end
            finished = halted;
        end
        // Pipeline must stay quiet once halted
        repeat (8) begin
            @(negedge clk);
            if (wb_valid) begin
                stop_with_error($sformatf("program %0d wrote back after halt", p));
            end
        end
        check_value("wb_count", 16'(n_seen), 16'(exp_reg.size()));
    endtask

    initial begin
        int p;
        rst_n = 1'b0;
        imem_data = halt_w;
        cur_prog = 0;
        err_count = 0;
        cycle_count = 0;
        build_table();
        for (p = 0; p < n_progs; p++) begin
            run_program(p);
        end
        if (err_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
cpu_pkg.sv
fetch_stage.sv
decode_stage.sv
hazard_unit.sv
execute_stage.sv
memory_stage.sv
cpu_top.sv
tb_cpu_top.sv

// ==== Makefile ====
TOP := tb_cpu_top
LOG := sim.log

all: run

build:
	verilator --binary --timing --timescale 1ns/1ps -f compile.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -Wall -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run lint clean
